// ==== source/dbg_pkg.sv ====
// Widths, opcodes, FSM states, TDO selects and CRC constants of the debug bus master
package dbg_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int DR_W      = 53;  // TAP data register
  localparam int DATA_W    = 32;  // Bus word and address
  localparam int COUNT_W   = 16;  // Burst word count
  localparam int BIT_CNT_W = 6;   // Counts up to 32 for the CRC phase
  localparam int REGSEL_W  = 1;   // One internal register today
  localparam int ERR_REG_W = 33;  // Address above the error bit

  localparam int WORD_BYTES = 4;  // Address step per word

  //////////////////////////////
  // CRC-32
  //////////////////////////////
  localparam logic [DATA_W-1:0] CRC_POLY = 32'hEDB8_8320;  // Reflected polynomial
  localparam logic [DATA_W-1:0] CRC_INIT = 32'hFFFF_FFFF;

  // Internal register index
  localparam logic [REGSEL_W-1:0] INTREG_ERROR = '0;

  // Module opcodes, the 8 and 16 bit bursts are not decoded
  typedef enum logic [3:0] {
    BWRITE32 = 4'd3,
    BREAD32  = 4'd7,
    IREG_WR  = 4'd9,
    IREG_SEL = 4'd13
  } opcode_e;

  // Burst FSM, high-speed mode only
  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } state_e;

  // Source of the TDO bit
  typedef enum logic [1:0] {
    READY,  // Bus status
    DATA,   // Output shift register LSB
    MATCH,  // Write CRC compare
    CRC     // CRC serial out
  } tdo_sel_e;

endpackage

// ==== source/dbg_cmd_decode.sv ====
// Data register field split and opcode classification
`timescale 1ns/1ns

module dbg_cmd_decode (
  input  logic [dbg_pkg::DR_W-1:0]     data_register_i,
  input  logic                         tdi_i,            // One bit ahead of bit 52
  output logic                         module_cmd_o,
  output logic                         burst_rd_o,
  output logic                         burst_wr_o,
  output logic                         ireg_sel_o,
  output logic                         ireg_wr_o,
  output dbg_pkg::opcode_e             opcode_o,
  output logic [dbg_pkg::DATA_W-1:0]   addr_o,
  output logic [dbg_pkg::COUNT_W-1:0]  count_o,
  output logic [dbg_pkg::REGSEL_W-1:0] regsel_o,
  output logic                         err_clear_o,
  output logic                         start_bit_o,
  output logic [dbg_pkg::DATA_W-1:0]   wdata_o
);

  // MSB low means the command is meant for a module
  assign module_cmd_o = ~data_register_i[52];
  assign start_bit_o  = data_register_i[52];  // Write burst start bit
  assign opcode_o     = dbg_pkg::opcode_e'(data_register_i[51:48]);
  assign addr_o       = data_register_i[47:16];
  assign count_o      = data_register_i[15:0];

  // Internal register commands reuse the address field
  assign regsel_o    = data_register_i[47 -: dbg_pkg::REGSEL_W];
  assign err_clear_o = data_register_i[46];  // Error register write data

  // Last bit still on tdi_i, the other 31 already in the register
  assign wdata_o = {tdi_i, data_register_i[52:22]};

  //////////////////////////////
  // Opcode classes
  //////////////////////////////
  always_comb begin
    burst_rd_o = 1'b0;
    burst_wr_o = 1'b0;
    ireg_sel_o = 1'b0;
    ireg_wr_o  = 1'b0;
    case (opcode_o)
      dbg_pkg::BREAD32:  burst_rd_o = 1'b1;
      dbg_pkg::BWRITE32: burst_wr_o = 1'b1;
      dbg_pkg::IREG_SEL: ireg_sel_o = 1'b1;
      dbg_pkg::IREG_WR: begin
        ireg_sel_o = 1'b1;  // A write also selects its register
        ireg_wr_o  = 1'b1;
      end
      default: ;  // Unknown opcodes do nothing
    endcase
  end

endmodule

// ==== source/dbg_burst_ctrl.sv ====
// Burst FSM with address, word and bit counters and the datapath strobes
`timescale 1ns/1ns

module dbg_burst_ctrl (
  input  logic                        tck_i,
  input  logic                        rst_i,
  input  logic                        module_select_i,
  input  logic                        capture_dr_i,
  input  logic                        shift_dr_i,
  input  logic                        update_dr_i,
  input  logic                        module_cmd_i,
  input  logic                        burst_rd_i,
  input  logic                        burst_wr_i,
  input  logic                        ireg_sel_i,
  input  logic                        ireg_wr_i,
  input  logic [dbg_pkg::DATA_W-1:0]  addr_i,
  input  logic [dbg_pkg::COUNT_W-1:0] count_i,
  input  logic                        start_bit_i,
  input  logic                        crc_match_i,
  input  logic                        bus_ready_i,
  output logic                        bus_start_o,
  output logic                        bus_clr_err_o,
  output logic                        bus_rd_o,
  output logic [dbg_pkg::DATA_W-1:0]  bus_addr_o,
  output logic                        out_ld_biu_o,
  output logic                        out_ld_ireg_o,
  output logic                        out_shift_o,
  output logic                        crc_clr_o,
  output logic                        crc_en_o,
  output logic                        crc_in_tdi_o,
  output logic                        crc_shift_o,
  output logic                        regsel_ld_o,
  output logic                        intreg_ld_o,
  output logic                        err_check_o,
  output dbg_pkg::tdo_sel_e           tdo_sel_o,
  output logic                        top_inhibit_o
);

  dbg_pkg::state_e               state_q, state_d;
  logic [dbg_pkg::DATA_W-1:0]    addr_q;
  logic [dbg_pkg::COUNT_W-1:0]   word_q;
  logic [dbg_pkg::BIT_CNT_W-1:0] bit_q;
  logic                          rd_q;       // Latched burst direction
  logic                          burst_ld;   // Take address, count and direction
  logic                          word_dec;
  logic                          bit_rst;
  logic                          bit_en;
  logic                          word_next;  // Read word done, load the next one
  logic                          cmd_upd;
  logic                          word_zero;
  logic                          bit_max;
  logic                          bit_32;

  assign cmd_upd   = module_select_i & module_cmd_i & update_dr_i;
  assign word_zero = (word_q == '0);
  assign bit_max   = (bit_q == dbg_pkg::BIT_CNT_W'(dbg_pkg::DATA_W - 1));
  assign bit_32    = (bit_q == dbg_pkg::BIT_CNT_W'(dbg_pkg::DATA_W));

  assign bus_addr_o = addr_q;
  assign bus_rd_o   = rd_q;

  //////////////////////////////
  // Next state and strobes
  //////////////////////////////
  always_comb begin
    state_d       = state_q;
    burst_ld      = 1'b0;
    word_dec      = 1'b0;
    bit_rst       = 1'b0;
    bit_en        = 1'b0;
    word_next     = 1'b0;
    bus_start_o   = 1'b0;
    bus_clr_err_o = 1'b0;
    out_ld_biu_o  = 1'b0;
    out_ld_ireg_o = 1'b0;
    out_shift_o   = 1'b0;
    crc_clr_o     = 1'b0;
    crc_en_o      = 1'b0;
    crc_in_tdi_o  = 1'b0;
    crc_shift_o   = 1'b0;
    regsel_ld_o   = 1'b0;
    intreg_ld_o   = 1'b0;
    err_check_o   = 1'b0;
    tdo_sel_o     = dbg_pkg::DATA;
    top_inhibit_o = 1'b1;  // Any burst state holds off the top level
    case (state_q)
      dbg_pkg::IDLE: begin
        top_inhibit_o = 1'b0;
        // Internal register access stays in IDLE
        out_shift_o   = module_select_i & shift_dr_i;
        out_ld_ireg_o = module_select_i & capture_dr_i;
        if (cmd_upd) begin
          regsel_ld_o = ireg_sel_i;
          intreg_ld_o = ireg_wr_i;
          if (burst_rd_i || burst_wr_i) begin
            burst_ld  = 1'b1;
            crc_clr_o = 1'b1;  // Fresh CRC per burst
            state_d   = burst_rd_i ? dbg_pkg::RBEGIN : dbg_pkg::WREADY;
          end
        end
      end
      dbg_pkg::RBEGIN: begin
        top_inhibit_o = 1'b0;
        if (word_zero) begin
          state_d = dbg_pkg::IDLE;  // Empty burst
        end else begin
          bus_start_o = 1'b1;  // First read runs while the TAP turns around
          state_d     = dbg_pkg::RREADY;
        end
      end
      dbg_pkg::RREADY: begin
        top_inhibit_o = 1'b0;
        if (module_select_i && capture_dr_i) state_d = dbg_pkg::RSTATUS;
      end
      dbg_pkg::RSTATUS: begin
        tdo_sel_o = dbg_pkg::READY;  // Host polls for a 1
        if (update_dr_i) begin
          state_d = dbg_pkg::IDLE;
        end else if (bus_ready_i) begin
          word_next = 1'b1;
          state_d   = dbg_pkg::RBURST;
        end
      end
      dbg_pkg::RBURST: begin
        out_shift_o = 1'b1;
        bit_en      = 1'b1;
        crc_en_o    = 1'b1;  // CRC follows the bit on TDO
        if (update_dr_i) begin
          state_d = dbg_pkg::IDLE;
        end else if (bit_max) begin
          if (word_zero) state_d = dbg_pkg::RCRC;
          else word_next = 1'b1;
        end
      end
      dbg_pkg::RCRC: begin
        tdo_sel_o   = dbg_pkg::CRC;
        crc_shift_o = 1'b1;  // No count, the host stops with update
        if (update_dr_i) state_d = dbg_pkg::IDLE;
      end
      dbg_pkg::WREADY: begin
        top_inhibit_o = 1'b0;
        if (word_zero) state_d = dbg_pkg::IDLE;
        else if (module_select_i && capture_dr_i) state_d = dbg_pkg::WWAIT;
      end
      dbg_pkg::WWAIT: begin
        if (update_dr_i) begin
          state_d = dbg_pkg::IDLE;
        end else if (module_select_i && start_bit_i) begin
          bus_clr_err_o = 1'b1;  // Drop a stale error from the last burst
          bit_en        = 1'b1;
          word_dec      = 1'b1;  // Pre-decrement
          crc_en_o      = 1'b1;
          crc_in_tdi_o  = 1'b1;  // First data bit is on tdi_i already
          state_d       = dbg_pkg::WBURST;
        end
      end
      dbg_pkg::WBURST: begin
        bit_en       = 1'b1;
        crc_en_o     = 1'b1;
        crc_in_tdi_o = 1'b1;
        if (update_dr_i) begin
          state_d = dbg_pkg::IDLE;
        end else if (bit_max) begin
          err_check_o = 1'b1;  // Previous write must be done
          bit_rst     = 1'b1;
          bus_start_o = 1'b1;
          word_dec    = 1'b1;
          if (word_zero) state_d = dbg_pkg::WCRC;
        end
      end
      dbg_pkg::WCRC: begin
        bit_en = 1'b1;
        if (update_dr_i) begin
          state_d = dbg_pkg::IDLE;
        end else if (bit_32) begin
          tdo_sel_o   = dbg_pkg::MATCH;  // This is the bit the host reads
          err_check_o = crc_match_i;     // bad CRC leaves the trap alone
          state_d     = dbg_pkg::WMATCH;
        end
      end
      dbg_pkg::WMATCH: begin
        tdo_sel_o = dbg_pkg::MATCH;
        if (update_dr_i) state_d = dbg_pkg::IDLE;
      end
      default: state_d = dbg_pkg::IDLE;
    endcase

    // Read word handoff, prefetch unless this is the last word
    if (word_next) begin
      err_check_o  = 1'b1;
      out_ld_biu_o = 1'b1;
      bit_rst      = 1'b1;
      word_dec     = 1'b1;
      bus_start_o  = (word_q > dbg_pkg::COUNT_W'(1));
    end
  end

  //////////////////////////////
  // State and counters
  //////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_pkg::IDLE;
      addr_q  <= '0;
      word_q  <= '0;
      bit_q   <= '0;
      rd_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (burst_ld) begin
        addr_q <= addr_i;
        word_q <= count_i;
        rd_q   <= burst_rd_i;
      end else begin
        if (bus_start_o) addr_q <= addr_q + dbg_pkg::DATA_W'(dbg_pkg::WORD_BYTES);
        if (word_dec && !word_zero) word_q <= word_q - 1'b1;  // Stops at zero
      end
      if (burst_ld || bit_rst) bit_q <= '0;
      else if (bit_en) bit_q <= bit_q + 1'b1;
    end
  end

endmodule

// ==== source/dbg_result_path.sv ====
// Output shift register, CRC-32, error and select registers, TDO multiplexer
`timescale 1ns/1ns

module dbg_result_path (
  input  logic                          tck_i,
  input  logic                          rst_i,
  input  logic                          tdi_i,
  input  logic                          out_ld_biu_i,
  input  logic                          out_ld_ireg_i,
  input  logic                          out_shift_i,
  input  logic                          crc_clr_i,
  input  logic                          crc_en_i,
  input  logic                          crc_in_tdi_i,
  input  logic                          crc_shift_i,
  input  logic                          regsel_ld_i,
  input  logic                          intreg_ld_i,
  input  logic                          err_check_i,
  input  dbg_pkg::tdo_sel_e             tdo_sel_i,
  input  logic [dbg_pkg::REGSEL_W-1:0]  regsel_i,
  input  logic                          err_clear_i,
  input  logic [dbg_pkg::DATA_W-1:0]    crc_ref_i,    // CRC as shifted in by the host
  input  logic [dbg_pkg::DATA_W-1:0]    bus_rdata_i,
  input  logic                          bus_ready_i,
  input  logic                          bus_err_i,
  input  logic                          bus_start_i,
  input  logic [dbg_pkg::DATA_W-1:0]    bus_addr_i,
  output logic                          crc_match_o,
  output logic                          module_tdo_o
);

  logic [dbg_pkg::ERR_REG_W-1:0] out_sr;
  logic [dbg_pkg::ERR_REG_W-1:0] err_reg;   // {address, error}
  logic [dbg_pkg::ERR_REG_W-1:0] ireg_data;
  logic [dbg_pkg::REGSEL_W-1:0]  regsel_q;
  logic [dbg_pkg::DATA_W-1:0]    crc_q;
  logic                          crc_din;

  // Room for more registers behind the select
  assign ireg_data = (regsel_q == dbg_pkg::INTREG_ERROR) ? err_reg : '0;

  //////////////////////////////
  // Output shift register
  //////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sr <= '0;
    end else if (out_ld_biu_i) begin
      out_sr <= {1'b0, bus_rdata_i};
    end else if (out_ld_ireg_i) begin
      out_sr <= ireg_data;
    end else if (out_shift_i) begin
      out_sr <= {1'b0, out_sr[dbg_pkg::ERR_REG_W-1:1]};  // LSB goes out first
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) regsel_q <= '0;
    else if (regsel_ld_i) regsel_q <= regsel_i;
  end

  // Error trap; address tracks each access until an error freezes it
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      err_reg <= '0;
    end else if (intreg_ld_i && (regsel_i == dbg_pkg::INTREG_ERROR)) begin
      if (err_clear_i) err_reg[0] <= 1'b0;  // Writing 1 clears the bit
    end else if (!err_reg[0]) begin
      if (err_check_i && (bus_err_i || !bus_ready_i)) begin
        err_reg[0] <= 1'b1;                  // Failed or unfinished access
      end else if (bus_start_i) begin
        err_reg[dbg_pkg::ERR_REG_W-1:1] <= bus_addr_i;
      end
    end
  end

  //////////////////////////////
  // Serial CRC-32
  //////////////////////////////
  assign crc_din = crc_in_tdi_i ? tdi_i : out_sr[0];  // Write data or read data

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= dbg_pkg::CRC_INIT;
    end else if (crc_clr_i) begin
      crc_q <= dbg_pkg::CRC_INIT;
    end else if (crc_en_i) begin
      crc_q <= (crc_q >> 1) ^ ((crc_din ^ crc_q[0]) ? dbg_pkg::CRC_POLY : '0);
    end else if (crc_shift_i) begin
      crc_q <= crc_q >> 1;  // Doubles as its own output register
    end
  end

  assign crc_match_o = (crc_ref_i == crc_q);

  // TDO
  always_comb begin
    case (tdo_sel_i)
      dbg_pkg::READY: module_tdo_o = bus_ready_i;
      dbg_pkg::DATA:  module_tdo_o = out_sr[0];
      dbg_pkg::MATCH: module_tdo_o = crc_match_o;
      default:        module_tdo_o = crc_q[0];
    endcase
  end

endmodule

// ==== source/dbg_bus_unit.sv ====
// Single access bus unit with a sticky error flag
`timescale 1ns/1ns

module dbg_bus_unit (
  input  logic                       tck_i,
  input  logic                       rst_i,
  input  logic                       clr_err_i,
  input  logic                       start_i,
  input  logic                       rd_i,
  input  logic [dbg_pkg::DATA_W-1:0] addr_i,
  input  logic [dbg_pkg::DATA_W-1:0] wdata_i,
  output logic [dbg_pkg::DATA_W-1:0] rdata_o,
  output logic                       ready_o,
  output logic                       err_o,
  output logic                       bus_cyc_o,
  output logic                       bus_we_o,
  output logic [dbg_pkg::DATA_W-1:0] bus_adr_o,
  output logic [dbg_pkg::DATA_W-1:0] bus_dat_o,
  input  logic [dbg_pkg::DATA_W-1:0] bus_dat_i,
  input  logic                       bus_ack_i,
  input  logic                       bus_err_i
);

  assign ready_o = ~bus_cyc_o;  // Idle means the last access is done

  // Cycle and error flag
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bus_cyc_o <= 1'b0;
      bus_we_o  <= 1'b0;
      err_o     <= 1'b0;
    end else begin
      if (start_i) begin
        bus_cyc_o <= 1'b1;
        bus_we_o  <= ~rd_i;
      end else if (bus_cyc_o && (bus_ack_i || bus_err_i)) begin
        bus_cyc_o <= 1'b0;  // Ends on the edge after the response
      end
      if (clr_err_i) err_o <= 1'b0;
      else if (bus_cyc_o && bus_err_i) err_o <= 1'b1;  // sticky
    end
  end

  // Access payload
  always_ff @(posedge tck_i) begin
    if (start_i) begin
      bus_adr_o <= addr_i;
      bus_dat_o <= wdata_i;
    end
    if (bus_cyc_o && bus_ack_i && !bus_we_o) rdata_o <= bus_dat_i;  // Read data
  end

endmodule

// ==== source/dbg_bus_module.sv ====
// Debug module bus master top level, decoder, controller, result path and bus unit
`timescale 1ns/1ns

module dbg_bus_module (
  input  logic                       tck_i,
  input  logic                       rst_i,
  input  logic                       tdi_i,
  input  logic                       capture_dr_i,
  input  logic                       shift_dr_i,
  input  logic                       update_dr_i,
  input  logic [dbg_pkg::DR_W-1:0]   data_register_i,
  input  logic                       module_select_i,
  output logic                       module_tdo_o,
  output logic                       top_inhibit_o,
  output logic                       bus_cyc_o,
  output logic                       bus_we_o,
  output logic [dbg_pkg::DATA_W-1:0] bus_adr_o,
  output logic [dbg_pkg::DATA_W-1:0] bus_dat_o,
  input  logic [dbg_pkg::DATA_W-1:0] bus_dat_i,
  input  logic                       bus_ack_i,
  input  logic                       bus_err_i
);

  // Decoded command
  logic                         module_cmd, burst_rd, burst_wr, ireg_sel, ireg_wr;
  logic [dbg_pkg::DATA_W-1:0]   cmd_addr, wdata;
  logic [dbg_pkg::COUNT_W-1:0]  cmd_count;
  logic [dbg_pkg::REGSEL_W-1:0] regsel;
  logic                         err_clear, start_bit;
  // Controller strobes
  logic                         bus_start, bus_clr_err, bus_rd;
  logic [dbg_pkg::DATA_W-1:0]   bus_addr;
  logic                         out_ld_biu, out_ld_ireg, out_shift;
  logic                         crc_clr, crc_en, crc_in_tdi, crc_shift;
  logic                         regsel_ld, intreg_ld, err_check;
  dbg_pkg::tdo_sel_e            tdo_sel;
  // Status back
  logic                         crc_match, bus_ready, bus_err;
  logic [dbg_pkg::DATA_W-1:0]   rdata;

  dbg_cmd_decode u_decode (
    .data_register_i (data_register_i), .tdi_i      (tdi_i),
    .module_cmd_o    (module_cmd),      .burst_rd_o (burst_rd),
    .burst_wr_o      (burst_wr),        .ireg_sel_o (ireg_sel),
    .ireg_wr_o       (ireg_wr),         .opcode_o   (),          // Debug visibility only
    .addr_o          (cmd_addr),        .count_o    (cmd_count),
    .regsel_o        (regsel),          .err_clear_o(err_clear),
    .start_bit_o     (start_bit),       .wdata_o    (wdata)
  );

  dbg_burst_ctrl u_ctrl (
    .tck_i         (tck_i),        .rst_i          (rst_i),
    .module_select_i(module_select_i), .capture_dr_i(capture_dr_i),
    .shift_dr_i    (shift_dr_i),   .update_dr_i    (update_dr_i),
    .module_cmd_i  (module_cmd),   .burst_rd_i     (burst_rd),
    .burst_wr_i    (burst_wr),     .ireg_sel_i     (ireg_sel),
    .ireg_wr_i     (ireg_wr),      .addr_i         (cmd_addr),
    .count_i       (cmd_count),    .start_bit_i    (start_bit),
    .crc_match_i   (crc_match),    .bus_ready_i    (bus_ready),
    .bus_start_o   (bus_start),    .bus_clr_err_o  (bus_clr_err),
    .bus_rd_o      (bus_rd),       .bus_addr_o     (bus_addr),
    .out_ld_biu_o  (out_ld_biu),   .out_ld_ireg_o  (out_ld_ireg),
    .out_shift_o   (out_shift),    .crc_clr_o      (crc_clr),
    .crc_en_o      (crc_en),       .crc_in_tdi_o   (crc_in_tdi),
    .crc_shift_o   (crc_shift),    .regsel_ld_o    (regsel_ld),
    .intreg_ld_o   (intreg_ld),    .err_check_o    (err_check),
    .tdo_sel_o     (tdo_sel),      .top_inhibit_o  (top_inhibit_o)
  );

  dbg_result_path u_result (
    .tck_i        (tck_i),        .rst_i        (rst_i),
    .tdi_i        (tdi_i),        .out_ld_biu_i (out_ld_biu),
    .out_ld_ireg_i(out_ld_ireg),  .out_shift_i  (out_shift),
    .crc_clr_i    (crc_clr),      .crc_en_i     (crc_en),
    .crc_in_tdi_i (crc_in_tdi),   .crc_shift_i  (crc_shift),
    .regsel_ld_i  (regsel_ld),    .intreg_ld_i  (intreg_ld),
    .err_check_i  (err_check),    .tdo_sel_i    (tdo_sel),
    .regsel_i     (regsel),       .err_clear_i  (err_clear),
    .crc_ref_i    (data_register_i[52:21]),  // Host CRC after 32 shifts
    .bus_rdata_i  (rdata),        .bus_ready_i  (bus_ready),
    .bus_err_i    (bus_err),      .bus_start_i  (bus_start),
    .bus_addr_i   (bus_addr),     .crc_match_o  (crc_match),
    .module_tdo_o (module_tdo_o)
  );

  dbg_bus_unit u_bus (
    .tck_i    (tck_i),      .rst_i    (rst_i),
    .clr_err_i(bus_clr_err), .start_i (bus_start),
    .rd_i     (bus_rd),     .addr_i   (bus_addr),
    .wdata_i  (wdata),      .rdata_o  (rdata),
    .ready_o  (bus_ready),  .err_o    (bus_err),
    .bus_cyc_o(bus_cyc_o),  .bus_we_o (bus_we_o),
    .bus_adr_o(bus_adr_o),  .bus_dat_o(bus_dat_o),
    .bus_dat_i(bus_dat_i),  .bus_ack_i(bus_ack_i),
    .bus_err_i(bus_err_i)
  );

endmodule

// ==== tests/dbg_module_props.sv ====
// Bound assertions on the debug bus master top level, inhibit, bus cycle hold and start spacing
`timescale 1ns/1ns

module dbg_module_props (
  input logic            tck_i,
  input logic            rst_i,
  input logic            top_inhibit_i,
  input logic            bus_cyc_i,
  input logic            bus_ack_i,
  input logic            bus_err_i,
  input logic            bus_start_i,
  input dbg_pkg::state_e state_i
);

  a_idle_inhibit: assert property (@(posedge tck_i) disable iff (rst_i)
    (state_i == dbg_pkg::IDLE) |-> !top_inhibit_i)
    else $error("top_inhibit_o high in IDLE");

  // Cycle holds until the slave answers
  a_cyc_hold: assert property (@(posedge tck_i) disable iff (rst_i)
    (bus_cyc_i && !bus_ack_i && !bus_err_i) |=> bus_cyc_i)
    else $error("bus_cyc_o dropped without ack or err");

  a_no_start: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_cyc_i |-> !bus_start_i)
    else $error("bus start while a cycle is open");

endmodule

bind dbg_bus_module dbg_module_props u_props (
  .tck_i        (tck_i),
  .rst_i        (rst_i),
  .top_inhibit_i(top_inhibit_o),
  .bus_cyc_i    (bus_cyc_o),
  .bus_ack_i    (bus_ack_i),
  .bus_err_i    (bus_err_i),
  .bus_start_i  (bus_start),
  .state_i      (u_ctrl.state_q)
);

// ==== tests/tb_dbg_module.sv ====
// Testbench for the debug bus master with TAP model, bus memory model, command table and checks
`timescale 1ns/1ns

module tb_dbg_module;

  localparam logic [31:0] POLY = 32'hEDB8_8320;  // Reflected CRC-32
  localparam int NROWS    = 5;
  localparam int POLL_MAX = 40;  // Status polls before giving up
  localparam logic [1:0] OP_WR = 2'd0, OP_RD = 2'd1, OP_ERR = 2'd2;

  logic        tck_i, rst_i, tdi_i, capture_dr_i, shift_dr_i, update_dr_i, module_select_i;
  logic [52:0] data_register_i;  // TAP data register model
  logic        module_tdo_o, top_inhibit_o, bus_cyc_o, bus_we_o;
  logic [31:0] bus_adr_o, bus_dat_o;
  logic [31:0] bus_dat_i = '0;
  logic        bus_ack_i = 1'b0;
  logic        bus_err_i = 1'b0;
  logic        acc_busy  = 1'b0;   // Memory model holds an access
  logic [1:0]  acc_wait  = '0;
  logic [7:0]  lfsr      = 8'd31;
  logic [31:0] mem [logic [31:0]];
  int          err_cnt, check_cnt;
  logic        timed_out;

  // Command table
  logic [1:0]  t_op   [NROWS];
  logic [31:0] t_addr [NROWS];
  logic [15:0] t_cnt  [NROWS];
  logic [31:0] t_seed [NROWS];
  logic        t_bad  [NROWS];  // Corrupt the host CRC

  dbg_bus_module u_dut (.*);

  initial begin
    tck_i = 1'b0;
    forever #20 tck_i = ~tck_i;
  end

  //////////////////////////////
  // Reference models
  //////////////////////////////
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // x^8+x^6+x^5+x^4
  endfunction

  task take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic b);
    return (crc >> 1) ^ ((b ^ crc[0]) ? POLY : 32'h0);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ (a * 32'h0001_0003) ^ 32'h5A5A_C3C3;  // Unwritten memory
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] word_val(input logic [31:0] seed, input int w);
    return seed ^ (32'(w) * 32'h1357_9BDF);
  endfunction

  // Bus memory with 0 to 3 wait cycles and err above 2 GB
  always @(negedge tck_i) begin
    logic b0, b1;
    bus_ack_i = 1'b0;
    bus_err_i = 1'b0;
    if (bus_cyc_o && !rst_i) begin
      if (!acc_busy) begin
        take_bit(b0);
        take_bit(b1);
        acc_wait = {b1, b0};
        acc_busy = 1'b1;
      end
      if (acc_wait == 2'd0) begin
        acc_busy = 1'b0;
        if (bus_adr_o[31]) bus_err_i = 1'b1;
        else begin
          bus_ack_i = 1'b1;
          if (bus_we_o) mem[bus_adr_o] = bus_dat_o;
          else bus_dat_i = mem_word(bus_adr_o);
        end
      end else acc_wait = acc_wait - 2'd1;
    end
  end

  //////////////////////////////
  // TAP sequences
  //////////////////////////////
  task check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // One TCK cycle with the DR shift of the last cycle landing before the new inputs
  task automatic step(input logic cap, sh, upd, b, ld, input logic [52:0] val,
                      output logic tdo);
    @(negedge tck_i);
    if (ld) data_register_i = val;
    else if (shift_dr_i) data_register_i = {tdi_i, data_register_i[52:1]};
    capture_dr_i = cap;
    shift_dr_i   = sh;
    update_dr_i  = upd;
    tdi_i        = b;
    #10;
    tdo = module_tdo_o;  // TDO seen by the edge that takes these inputs
  endtask

  task automatic send_cmd(input logic [52:0] val);
    logic t;
    step(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, val, t);
  endtask

  task automatic read_ireg(output logic [32:0] v);
    logic t;
    send_cmd({1'b0, 4'd13, 48'h0});  // Select the error register
    step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);
    for (int i = 0; i < 33; i++) begin
      step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, t);
      v[i] = t;
    end
    step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);
  endtask

  task automatic run_write(input logic [31:0] addr, input logic [15:0] cnt,
                           input logic [31:0] seed, input logic bad, output logic match);
    logic        t;
    logic [31:0] crc, wv;
    crc = 32'hFFFF_FFFF;
    send_cmd({1'b0, 4'd3, addr, cnt});
    step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);
    step(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, '0, t);  // Start bit
    for (int w = 0; w < int'(cnt); w++) begin
      wv = word_val(seed, w);
      for (int i = 0; i < 32; i++) begin
        step(1'b0, 1'b1, 1'b0, wv[i], 1'b0, '0, t);
        crc = crc_next(crc, wv[i]);
      end
    end
    if (bad) crc = crc ^ 32'h1;
    for (int i = 0; i < 32; i++) step(1'b0, 1'b1, 1'b0, crc[i], 1'b0, '0, t);
    step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, match);  // Match bit
    step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, '0, t);
  endtask

  task automatic run_read(input logic [31:0] addr, input logic [15:0] cnt);
    logic        t;
    int          n;
    logic [31:0] crc, got, exp;
    crc = 32'hFFFF_FFFF;
    send_cmd({1'b0, 4'd7, addr, cnt});
    step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);  // First read issued
    step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);
    t = 1'b0;
    n = 0;
    while (!t && n < POLL_MAX) begin
      step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, t);  // Poll status
      n++;
    end
    if (!t) begin
      timed_out = 1'b1;
      $display("Timeout: read status bit stayed 0 at %0t", $time);
    end else begin
      for (int w = 0; w < int'(cnt); w++) begin
        exp = mem_word(addr + 32'(4 * w));
        for (int i = 0; i < 32; i++) begin
          step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, t);
          got[i] = t;
          crc    = crc_next(crc, exp[i]);
        end
        check_val(64'(got), 64'(exp), "read word");
      end
      for (int i = 0; i < 32; i++) begin
        step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, '0, t);
        got[i] = t;
      end
      check_val(64'(got), 64'(crc), "read CRC");
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, '0, t);
    end
  endtask

  // Fill one command table row
  task set_row(input int r, input logic [1:0] op, input logic [31:0] addr,
               input logic [15:0] cnt, input logic [31:0] seed, input logic bad);
    t_op[r]   = op;
    t_addr[r] = addr;
    t_cnt[r]  = cnt;
    t_seed[r] = seed;
    t_bad[r]  = bad;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin : stim
    logic        t, match;
    logic [32:0] v;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;
    data_register_i = '0;
    err_cnt   = 0;
    check_cnt = 0;
    timed_out = 1'b0;
    set_row(0, OP_WR,  32'h100,       16'd3, 32'hC0DE_0001, 1'b0);
    set_row(1, OP_WR,  32'h200,       16'd2, 32'h1BAD_F00D, 1'b1);
    set_row(2, OP_RD,  32'h100,       16'd3, '0,            1'b0);
    set_row(3, OP_RD,  32'h400,       16'd2, '0,            1'b0);
    set_row(4, OP_ERR, 32'h8000_0040, 16'd1, 32'h0F0F_0F0F, 1'b0);
    repeat (3) @(posedge tck_i);
    @(negedge tck_i);
    rst_i = 1'b0;
    step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, t);
    check_val(64'({module_tdo_o, top_inhibit_o, bus_cyc_o}), 64'h0, "outputs after reset");
    read_ireg(v);
    check_val(64'(v), 64'h0, "error register after reset");
    for (int r = 0; r < NROWS; r++) begin
      if (!timed_out) begin
        case (t_op[r])
          OP_WR: begin
            run_write(t_addr[r], t_cnt[r], t_seed[r], t_bad[r], match);
            check_val(64'(match), 64'(!t_bad[r]), "write match bit");
            for (int w = 0; w < int'(t_cnt[r]); w++)
              check_val(64'(mem_word(t_addr[r] + 32'(4 * w))),
                        64'(word_val(t_seed[r], w)), "memory word");
          end
          OP_RD: run_read(t_addr[r], t_cnt[r]);
          default: begin
            run_write(t_addr[r], t_cnt[r], t_seed[r], 1'b0, match);
            check_val(64'(match), 64'h1, "error burst match bit");
            read_ireg(v);
            check_val(64'(v), 64'({t_addr[r], 1'b1}), "trapped error register");
            send_cmd({1'b0, 4'd9, 1'b0, 1'b1, 46'h0});  // Clear the error bit
            read_ireg(v);
            check_val(64'(v), 64'({t_addr[r], 1'b0}), "cleared error register");
          end
        endcase
      end
    end
    $display("Checks run: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timed_out);
    if (timed_out || err_cnt != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
source/dbg_pkg.sv
source/dbg_cmd_decode.sv
source/dbg_burst_ctrl.sv
source/dbg_result_path.sv
source/dbg_bus_unit.sv
source/dbg_bus_module.sv
tests/dbg_module_props.sv
tests/tb_dbg_module.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the debug bus master testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_dbg_module -o sim_dbg
out=$(./obj_dir/sim_dbg)
echo "$out"
echo "$out" | grep -qx "Test OK"
